/* hw/gat_dims_pkg.sv */
`default_nettype none

package gat_dims_pkg;

  // Feature values, weights and attention elements
  localparam int DATA_W = 8;
  typedef logic signed [DATA_W-1:0] data_t;

  // One WH element that wraps at this width
  localparam int WH_W = 12;
  typedef logic signed [WH_W-1:0] wh_t;

  // Scores and coefficients wrap the same way
  localparam int SCORE_W = 19;
  typedef logic signed [SCORE_W-1:0] score_t;

  // Largest layer the memory layouts are sized for
  localparam int MAX_FEATURE_IN  = 16;
  localparam int MAX_FEATURE_OUT = 8;

endpackage

`default_nettype wire

/* hw/gat_mem_pkg.sv */
`default_nettype none

package gat_mem_pkg;

  localparam int COL_IDX_W   = $clog2(gat_dims_pkg::MAX_FEATURE_IN);
  // Row length counts up to MAX_FEATURE_IN inclusive
  localparam int ROW_LEN_W   = $clog2(gat_dims_pkg::MAX_FEATURE_IN) + 1;
  localparam int H_ADDR_W    = 10;
  localparam int NODE_ADDR_W = 8;

  // Weight memory holds W row-major by input feature followed by a-self and a-neighbour
  localparam int WGT_ADDR_W  = $clog2(gat_dims_pkg::MAX_FEATURE_IN * gat_dims_pkg::MAX_FEATURE_OUT
                                      + 2 * gat_dims_pkg::MAX_FEATURE_OUT);

  // One nonzero of H
  typedef struct packed {
    gat_dims_pkg::data_t    value;
    logic [COL_IDX_W-1:0]   col_idx;
  } h_entry_t;

  // Per-node row descriptor
  typedef struct packed {
    logic [ROW_LEN_W-1:0]   row_len;
    logic                   first;
  } node_info_t;

endpackage

`default_nettype wire

/* hw/gat_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module gat_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic req_i,
  input  logic wload_last_i,
  input  logic row_last_i,
  input  logic row_empty_i,
  input  logic node_last_i,
  output logic ack_o,
  output logic wload_cnt_en_o,
  output logic wload_en_o,
  output logic node_cnt_en_o,
  output logic row_load_o,
  output logic row_cnt_en_o,
  output logic acc_clr_o,
  output logic acc_en_o,
  output logic row_done_o,
  output logic cnt_clr_o
);

  typedef enum logic [2:0] {
    IDLE,
    LOAD_W,
    INFO_RD,
    INFO_LATCH,
    ROW,
    SCORE,
    ACK
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   node_end;
  logic   row_end_q;
  logic   ack_dly_q;

  // Last H address of the current node goes out this cycle
  assign node_end = (state_q == INFO_LATCH && row_empty_i) || (state_q == ROW && row_last_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:       if (req_i) state_d = LOAD_W;
      LOAD_W:     if (wload_last_i) state_d = INFO_RD;
      INFO_RD:    state_d = INFO_LATCH;
      INFO_LATCH: begin
        if (!row_empty_i) begin
          state_d = ROW;
        end else begin
          state_d = node_last_i ? SCORE : INFO_RD;
        end
      end
      ROW:        if (row_last_i) state_d = node_last_i ? SCORE : INFO_RD;
      // Wait for the final row to drain
      SCORE:      if (row_done_o) state_d = ACK;
      ACK:        if (!req_i) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  assign wload_cnt_en_o = (state_q == LOAD_W);
  assign row_load_o     = (state_q == INFO_LATCH);
  assign row_cnt_en_o   = (state_q == ROW);
  assign node_cnt_en_o  = node_end && !node_last_i;
  assign cnt_clr_o      = (state_q == IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      wload_en_o <= 1'b0;
      acc_en_o   <= 1'b0;
      acc_clr_o  <= 1'b0;
      row_end_q  <= 1'b0;
      row_done_o <= 1'b0;
      ack_dly_q  <= 1'b0;
      ack_o      <= 1'b0;
    end else begin
      state_q    <= state_d;
      // Read data trails its address by one cycle
      wload_en_o <= (state_q == LOAD_W);
      acc_en_o   <= (state_q == ROW);
      // Lands on the latch cycle as the previous WH is taken
      acc_clr_o  <= (state_q == INFO_RD);
      row_end_q  <= (state_q == ROW) && row_last_i;
      row_done_o <= row_end_q || (state_q == INFO_LATCH && row_empty_i);
      ack_dly_q  <= (state_q == ACK) && req_i;
      ack_o      <= ack_dly_q && req_i;
    end
  end

endmodule

`default_nettype wire

/* hw/gat_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module gat_counters #(
  parameter int NUM_FEATURE_IN  = 8,
  parameter int NUM_FEATURE_OUT = 4,
  parameter int TOTAL_NODES     = 12
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cnt_clr_i,
  input  logic                                wload_cnt_en_i,
  input  logic                                node_cnt_en_i,
  input  logic                                row_load_i,
  input  logic                                row_cnt_en_i,
  input  gat_mem_pkg::node_info_t             node_info_i,
  output logic [gat_mem_pkg::WGT_ADDR_W-1:0]  wgt_addr_o,
  output logic [gat_mem_pkg::NODE_ADDR_W-1:0] node_addr_o,
  output logic [gat_mem_pkg::H_ADDR_W-1:0]    h_addr_o,
  output logic [gat_mem_pkg::NODE_ADDR_W-1:0] node_idx_o,
  output logic                                first_o,
  output logic                                wload_last_o,
  output logic                                row_last_o,
  output logic                                row_empty_o,
  output logic                                node_last_o
);

  import gat_mem_pkg::*;

  localparam int WGT_WORDS = NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT;

  // Entries still to be addressed in the current row
  logic [ROW_LEN_W-1:0] row_rem_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_addr_o  <= '0;
      node_addr_o <= '0;
      h_addr_o    <= '0;
      node_idx_o  <= '0;
      first_o     <= 1'b0;
      row_rem_q   <= '0;
    end else if (cnt_clr_i) begin
      wgt_addr_o  <= '0;
      node_addr_o <= '0;
      h_addr_o    <= '0;
      node_idx_o  <= '0;
      first_o     <= 1'b0;
      row_rem_q   <= '0;
    end else begin
      if (wload_cnt_en_i) begin
        wgt_addr_o <= wgt_addr_o + 1'b1;
      end
      if (node_cnt_en_i) begin
        node_addr_o <= node_addr_o + 1'b1;
      end
      // H pointer runs on across rows
      if (row_cnt_en_i) begin
        h_addr_o <= h_addr_o + 1'b1;
      end
      // Held for the score stage that trails the next descriptor read
      if (row_load_i) begin
        row_rem_q  <= node_info_i.row_len;
        first_o    <= node_info_i.first;
        node_idx_o <= node_addr_o;
      end else if (row_cnt_en_i) begin
        row_rem_q <= row_rem_q - 1'b1;
      end
    end
  end

  assign wload_last_o = (wgt_addr_o == WGT_ADDR_W'(WGT_WORDS - 1));
  assign node_last_o  = (node_addr_o == NODE_ADDR_W'(TOTAL_NODES - 1));
  assign row_last_o   = (row_rem_q == ROW_LEN_W'(1));
  assign row_empty_o  = (node_info_i.row_len == '0);

endmodule

`default_nettype wire

/* hw/gat_weight_store.sv */
`timescale 1ns/1ps
`default_nettype none

module gat_weight_store #(
  parameter int NUM_FEATURE_IN  = 8,
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      wload_en_i,
  input  gat_dims_pkg::data_t                       wgt_data_i,
  input  logic [gat_mem_pkg::COL_IDX_W-1:0]         col_idx_i,
  output gat_dims_pkg::data_t [NUM_FEATURE_OUT-1:0] w_row_o,
  output gat_dims_pkg::data_t [NUM_FEATURE_OUT-1:0] a_self_o,
  output gat_dims_pkg::data_t [NUM_FEATURE_OUT-1:0] a_neigh_o
);

  import gat_dims_pkg::*;

  localparam int W_WORDS   = NUM_FEATURE_IN * NUM_FEATURE_OUT;
  localparam int WGT_WORDS = W_WORDS + 2 * NUM_FEATURE_OUT;
  localparam int IDX_W     = $clog2(WGT_WORDS);

  data_t            wgt_q [WGT_WORDS];
  logic [IDX_W-1:0] wr_idx_q;
  int               row_base;

  // Wraps after a-neighbour so the next request starts at W again
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_idx_q <= '0;
    end else if (wload_en_i) begin
      wr_idx_q <= (wr_idx_q == IDX_W'(WGT_WORDS - 1)) ? '0 : wr_idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wload_en_i) begin
      wgt_q[wr_idx_q] <= wgt_data_i;
    end
  end

  // Out of range columns fall back to row 0
  assign row_base = (int'(col_idx_i) < NUM_FEATURE_IN) ? int'(col_idx_i) * NUM_FEATURE_OUT : 0;

  always_comb begin
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      w_row_o[j]   = wgt_q[row_base + j];
      a_self_o[j]  = wgt_q[W_WORDS + j];
      a_neigh_o[j] = wgt_q[W_WORDS + NUM_FEATURE_OUT + j];
    end
  end

endmodule

`default_nettype wire

/* hw/gat_spmm.sv */
`timescale 1ns/1ps
`default_nettype none

module gat_spmm #(
  parameter int NUM_FEATURE_IN  = 8,
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      acc_clr_i,
  input  logic                                      acc_en_i,
  input  gat_mem_pkg::h_entry_t                     h_entry_i,
  input  gat_dims_pkg::data_t [NUM_FEATURE_OUT-1:0] w_row_i,
  output gat_dims_pkg::wh_t   [NUM_FEATURE_OUT-1:0] wh_o
);

  import gat_dims_pkg::*;

  logic                       col_ok;
  logic signed [2*DATA_W-1:0] prod [NUM_FEATURE_OUT];

  // Entries beyond the layer width add nothing
  assign col_ok = (int'(h_entry_i.col_idx) < NUM_FEATURE_IN);

  always_comb begin
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      prod[j] = $signed(h_entry_i.value) * $signed(w_row_i[j]);
    end
  end

  // One accumulator per output feature that wraps at WH_W
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_o <= '0;
    end else if (acc_clr_i) begin
      wh_o <= '0;
    end else if (acc_en_i && col_ok) begin
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        wh_o[j] <= wh_o[j] + wh_t'(prod[j]);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/gat_score.sv */
`timescale 1ns/1ps
`default_nettype none

module gat_score #(
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      row_done_i,
  input  logic                                      first_i,
  input  logic [gat_mem_pkg::NODE_ADDR_W-1:0]       node_idx_i,
  input  gat_dims_pkg::wh_t   [NUM_FEATURE_OUT-1:0] wh_i,
  input  gat_dims_pkg::data_t [NUM_FEATURE_OUT-1:0] a_self_i,
  input  gat_dims_pkg::data_t [NUM_FEATURE_OUT-1:0] a_neigh_i,
  output logic                                      node_vld_o,
  output logic [gat_mem_pkg::NODE_ADDR_W-1:0]       node_idx_o,
  output gat_dims_pkg::wh_t   [NUM_FEATURE_OUT-1:0] wh_o,
  output gat_dims_pkg::score_t                      coef_o
);

  import gat_dims_pkg::*;

  score_t self_score;
  score_t neigh_score;
  score_t centre_q;
  score_t centre_now;

  function automatic score_t dot(input data_t [NUM_FEATURE_OUT-1:0] a,
                                 input wh_t   [NUM_FEATURE_OUT-1:0] v);
    score_t                          sum;
    logic signed [DATA_W+WH_W-1:0]   prod;
    sum = '0;
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      prod = $signed(a[j]) * $signed(v[j]);
      sum  = sum + score_t'(prod);
    end
    return sum;
  endfunction

  assign self_score  = dot(a_self_i, wh_i);
  assign neigh_score = dot(a_neigh_i, wh_i);

  // A first node is its own centre
  assign centre_now  = first_i ? self_score : centre_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_vld_o <= 1'b0;
      centre_q   <= '0;
    end else begin
      node_vld_o <= row_done_i;
      if (row_done_i) begin
        centre_q <= centre_now;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_done_i) begin
      node_idx_o <= node_idx_i;
      wh_o       <= wh_i;
      coef_o     <= centre_now + neigh_score;
    end
  end

endmodule

`default_nettype wire

/* hw/gat_core.sv */
`timescale 1ns/1ps
`default_nettype none

module gat_core #(
  parameter int NUM_FEATURE_IN  = 8,
  parameter int NUM_FEATURE_OUT = 4,
  parameter int TOTAL_NODES     = 12
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    req_i,
  input  gat_dims_pkg::data_t                     wgt_data_i,
  input  gat_mem_pkg::node_info_t                 node_info_i,
  input  gat_mem_pkg::h_entry_t                   h_entry_i,
  output logic                                    ack_o,
  output logic [gat_mem_pkg::WGT_ADDR_W-1:0]      wgt_addr_o,
  output logic [gat_mem_pkg::NODE_ADDR_W-1:0]     node_addr_o,
  output logic [gat_mem_pkg::H_ADDR_W-1:0]        h_addr_o,
  output logic                                    node_vld_o,
  output logic [gat_mem_pkg::NODE_ADDR_W-1:0]     node_idx_o,
  output gat_dims_pkg::wh_t [NUM_FEATURE_OUT-1:0] wh_o,
  output gat_dims_pkg::score_t                    coef_o
);

  import gat_dims_pkg::*;
  import gat_mem_pkg::*;

  logic wload_last, row_last, row_empty, node_last;
  logic wload_cnt_en, wload_en, node_cnt_en, row_load, row_cnt_en;
  logic acc_clr, acc_en, row_done, cnt_clr, first;

  logic [NODE_ADDR_W-1:0]      node_idx;
  data_t [NUM_FEATURE_OUT-1:0] w_row;
  data_t [NUM_FEATURE_OUT-1:0] a_self;
  data_t [NUM_FEATURE_OUT-1:0] a_neigh;
  wh_t   [NUM_FEATURE_OUT-1:0] wh_vec;

  gat_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .wload_last_i   (wload_last),
    .row_last_i     (row_last),
    .row_empty_i    (row_empty),
    .node_last_i    (node_last),
    .ack_o          (ack_o),
    .wload_cnt_en_o (wload_cnt_en),
    .wload_en_o     (wload_en),
    .node_cnt_en_o  (node_cnt_en),
    .row_load_o     (row_load),
    .row_cnt_en_o   (row_cnt_en),
    .acc_clr_o      (acc_clr),
    .acc_en_o       (acc_en),
    .row_done_o     (row_done),
    .cnt_clr_o      (cnt_clr)
  );

  gat_counters #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .TOTAL_NODES     (TOTAL_NODES)
  ) u_counters (
    .clk            (clk),
    .rst_n          (rst_n),
    .cnt_clr_i      (cnt_clr),
    .wload_cnt_en_i (wload_cnt_en),
    .node_cnt_en_i  (node_cnt_en),
    .row_load_i     (row_load),
    .row_cnt_en_i   (row_cnt_en),
    .node_info_i    (node_info_i),
    .wgt_addr_o     (wgt_addr_o),
    .node_addr_o    (node_addr_o),
    .h_addr_o       (h_addr_o),
    .node_idx_o     (node_idx),
    .first_o        (first),
    .wload_last_o   (wload_last),
    .row_last_o     (row_last),
    .row_empty_o    (row_empty),
    .node_last_o    (node_last)
  );

  gat_weight_store #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_weight_store (
    .clk        (clk),
    .rst_n      (rst_n),
    .wload_en_i (wload_en),
    .wgt_data_i (wgt_data_i),
    .col_idx_i  (h_entry_i.col_idx),
    .w_row_o    (w_row),
    .a_self_o   (a_self),
    .a_neigh_o  (a_neigh)
  );

  gat_spmm #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_spmm (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_clr_i (acc_clr),
    .acc_en_i  (acc_en),
    .h_entry_i (h_entry_i),
    .w_row_i   (w_row),
    .wh_o      (wh_vec)
  );

  gat_score #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_score (
    .clk        (clk),
    .rst_n      (rst_n),
    .row_done_i (row_done),
    .first_i    (first),
    .node_idx_i (node_idx),
    .wh_i       (wh_vec),
    .a_self_i   (a_self),
    .a_neigh_i  (a_neigh),
    .node_vld_o (node_vld_o),
    .node_idx_o (node_idx_o),
    .wh_o       (wh_o),
    .coef_o     (coef_o)
  );

endmodule

`default_nettype wire

/* bench/tb_gat_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gat_core;

  import gat_dims_pkg::*;
  import gat_mem_pkg::*;

  localparam int NUM_FEATURE_IN  = 8;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int TOTAL_NODES     = 12;
  localparam int WGT_DEPTH       = 1 << WGT_ADDR_W;
  localparam int NODE_DEPTH      = 1 << NODE_ADDR_W;
  localparam int H_DEPTH         = 1 << H_ADDR_W;
  localparam int ACK_TIMEOUT     = 1000;
  localparam int FALL_TIMEOUT    = 16;
  localparam int NUM_CASES       = 5;

  // Case table of longest row, value range and centre spacing
  int max_len_tab [NUM_CASES] = '{0, 3, 8, 5, 8};
  int range_tab   [NUM_CASES] = '{5, 7, 127, 127, 20};
  int spacing_tab [NUM_CASES] = '{3, 4, 1, 12, 5};

  logic                               clk;
  logic                               rst_n;
  logic                               req;
  logic                               ack;
  data_t                              wgt_data  = '0;
  node_info_t                         node_info = '0;
  h_entry_t                           h_entry   = '0;
  logic [WGT_ADDR_W-1:0]              wgt_addr;
  logic [NODE_ADDR_W-1:0]             node_addr;
  logic [H_ADDR_W-1:0]                h_addr;
  logic                               node_vld;
  logic [NODE_ADDR_W-1:0]             node_idx;
  wh_t [NUM_FEATURE_OUT-1:0]          wh;
  score_t                             coef;

  // Memory contents and address of the previous cycle
  data_t                  wgt_mem  [WGT_DEPTH];
  node_info_t             node_mem [NODE_DEPTH];
  h_entry_t               h_mem    [H_DEPTH];
  logic [WGT_ADDR_W-1:0]  wgt_addr_q  = '0;
  logic [NODE_ADDR_W-1:0] node_addr_q = '0;
  logic [H_ADDR_W-1:0]    h_addr_q    = '0;

  // Reference values for the current request
  int     w_ref       [NUM_FEATURE_IN][NUM_FEATURE_OUT];
  int     a_self_ref  [NUM_FEATURE_OUT];
  int     a_neigh_ref [NUM_FEATURE_OUT];
  wh_t    exp_wh      [TOTAL_NODES][NUM_FEATURE_OUT];
  score_t exp_coef    [TOTAL_NODES];

  int errors;
  int checks;
  int tests_run;
  bit hung;

  gat_core #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .TOTAL_NODES     (TOTAL_NODES)
  ) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req),
    .wgt_data_i  (wgt_data),
    .node_info_i (node_info),
    .h_entry_i   (h_entry),
    .ack_o       (ack),
    .wgt_addr_o  (wgt_addr),
    .node_addr_o (node_addr),
    .h_addr_o    (h_addr),
    .node_vld_o  (node_vld),
    .node_idx_o  (node_idx),
    .wh_o        (wh),
    .coef_o      (coef)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Data for last cycle's address lands before the next rising edge
  always @(negedge clk) begin
    wgt_data    <= wgt_mem[wgt_addr_q];
    node_info   <= node_mem[node_addr_q];
    h_entry     <= h_mem[h_addr_q];
    wgt_addr_q  <= wgt_addr;
    node_addr_q <= node_addr;
    h_addr_q    <= h_addr;
  end

  function automatic int pick_signed(input int range);
    int v;
    v = int'($urandom_range(2 * range, 0)) - range;
    return v;
  endfunction

  task automatic flag_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic check_wh(input int node, input int j, input wh_t got, input wh_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error wh_o[%0d] at node %0d: got %h, expected %h", j, node, got, exp);
    end
  endtask

  task automatic check_coef(input int node, input score_t got, input score_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error coef_o at node %0d: got %h, expected %h", node, got, exp);
    end
  endtask

  task automatic check_idx(input logic [NODE_ADDR_W-1:0] got,
                           input logic [NODE_ADDR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error node_idx_o: got %h, expected %h", got, exp);
    end
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (ack) flag_failure("ack_o went high with no request");
      if (node_vld) flag_failure("node_vld_o went high with no request");
    end
  endtask

  // Fills the three memories and derives the expected results
  task automatic load_case(input int max_len, input int range, input int spacing);
    int         ptr;
    int         len;
    int         col;
    int         v;
    int         self_sum;
    int         neigh_sum;
    int         acc [NUM_FEATURE_OUT];
    score_t     centre;
    node_info_t ni;
    h_entry_t   he;
    wh_t        wh_tmp;
    for (int a = 0; a < WGT_DEPTH; a++) wgt_mem[a] = data_t'(a ^ 'h5a);
    for (int a = 0; a < NODE_DEPTH; a++) node_mem[a] = 6'(a ^ (a >> 6));
    for (int a = 0; a < H_DEPTH; a++) h_mem[a] = 12'(a ^ 'h9c5);
    for (int i = 0; i < NUM_FEATURE_IN; i++) begin
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        w_ref[i][j] = pick_signed(range);
        wgt_mem[i * NUM_FEATURE_OUT + j] = data_t'(w_ref[i][j]);
      end
    end
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      a_self_ref[j]  = pick_signed(range);
      a_neigh_ref[j] = pick_signed(range);
      wgt_mem[NUM_FEATURE_IN * NUM_FEATURE_OUT + j] = data_t'(a_self_ref[j]);
      wgt_mem[NUM_FEATURE_IN * NUM_FEATURE_OUT + NUM_FEATURE_OUT + j] = data_t'(a_neigh_ref[j]);
    end
    ptr    = 0;
    centre = '0;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      len        = int'($urandom_range(max_len, 0));
      ni.row_len = ROW_LEN_W'(len);
      ni.first   = (n % spacing == 0);
      node_mem[n] = ni;
      for (int j = 0; j < NUM_FEATURE_OUT; j++) acc[j] = 0;
      for (int e = 0; e < len; e++) begin
        col = int'($urandom_range(NUM_FEATURE_IN - 1, 0));
        v   = pick_signed(range);
        if (v == 0) v = 1;
        he.value   = data_t'(v);
        he.col_idx = COL_IDX_W'(col);
        h_mem[ptr] = he;
        ptr++;
        for (int j = 0; j < NUM_FEATURE_OUT; j++) acc[j] += v * w_ref[col][j];
      end
      self_sum  = 0;
      neigh_sum = 0;
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        wh_tmp       = wh_t'(acc[j]);
        exp_wh[n][j] = wh_tmp;
        self_sum    += a_self_ref[j] * int'(wh_tmp);
        neigh_sum   += a_neigh_ref[j] * int'(wh_tmp);
      end
      if (ni.first) centre = score_t'(self_sum);
      exp_coef[n] = score_t'(int'(centre) + neigh_sum);
    end
  endtask

  // One four-phase request with result checks on the way
  task automatic run_request();
    int cyc;
    int pulses;
    int since_vld;
    @(negedge clk);
    req       = 1'b1;
    pulses    = 0;
    since_vld = -1;
    cyc       = 0;
    while (!ack && cyc < ACK_TIMEOUT) begin
      @(negedge clk);
      cyc++;
      if (since_vld >= 0) since_vld++;
      if (node_vld) begin
        if (pulses < TOTAL_NODES) begin
          check_idx(node_idx, NODE_ADDR_W'(pulses));
          for (int j = 0; j < NUM_FEATURE_OUT; j++) check_wh(pulses, j, wh[j], exp_wh[pulses][j]);
          check_coef(pulses, coef, exp_coef[pulses]);
        end
        pulses++;
        since_vld = 0;
      end
    end
    if (!ack) begin
      flag_failure("timed out waiting for ack_o to rise");
      hung = 1'b1;
      return;
    end
    if (pulses != TOTAL_NODES) begin
      flag_failure($sformatf("saw %0d node_vld_o pulses before ack_o, wanted %0d",
                             pulses, TOTAL_NODES));
    end
    if (since_vld != 2) begin
      flag_failure($sformatf("ack_o rose %0d cycles after the last node_vld_o, wanted 2",
                             since_vld));
    end
    // Ack must hold while the request is still up
    repeat (2) begin
      @(negedge clk);
      if (!ack) flag_failure("ack_o dropped while req_i was still high");
      if (node_vld) flag_failure("node_vld_o pulsed after ack_o");
    end
    req = 1'b0;
    cyc = 0;
    while (ack && cyc < FALL_TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (ack) begin
      flag_failure("timed out waiting for ack_o to fall");
      hung = 1'b1;
    end
  endtask

  initial begin
    int errors_before;
    void'($urandom(32'h48b6));
    rst_n     = 1'b0;
    req       = 1'b0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    hung      = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_idle(8);
    for (int t = 0; t < NUM_CASES && !hung; t++) begin
      errors_before = errors;
      load_case(max_len_tab[t], range_tab[t], spacing_tab[t]);
      run_request();
      tests_run++;
      $display("test %0d: max row %0d, range %0d, centre every %0d nodes, %0d mismatches",
               t, max_len_tab[t], range_tab[t], spacing_tab[t], errors - errors_before);
    end
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/gat_dims_pkg.sv
hw/gat_mem_pkg.sv
hw/gat_ctrl.sv
hw/gat_counters.sv
hw/gat_weight_store.sv
hw/gat_spmm.sv
hw/gat_score.sv
hw/gat_core.sv
bench/tb_gat_core.sv

/* Makefile */
TOP := tb_gat_core

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
